// ==== Makefile ====
# Verilator build and run for the period meter testbench.
# The run passes only if the log holds the pass line.

TOP = tb_period_meter
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/period_meter_checker.sv ====
// Scoreboard for the period meter testbench.
// Takes one expected display value per test and compares it with the DUT
// output on every o_valid pulse. Prints a line per test and a closing summary.
`timescale 1ns/1ps
`default_nettype none

module period_meter_checker
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_push,
    input  wire period_meter_pkg::display_t i_expected,
    input  wire                             i_valid,
    input  wire period_meter_pkg::display_t i_display,
    input  wire                             i_report,
    output int                              o_pending,
    output int                              o_errors
);

    import period_meter_pkg::*;

    display_t exp_q[$];
    int       pushed;
    int       checked;
    int       passed;
    int       valid_count;

    task automatic compare_result(input display_t expected);
        bit ok;
        ok = (i_display.underflow == expected.underflow) &&
             (i_display.overflow == expected.overflow);
        // Digits only carry meaning when no flag is set.
        if (!expected.underflow && !expected.overflow)
        begin
            ok = ok && (i_display.digits == expected.digits);
        end
        if (ok)
        begin
            passed++;
            $display("test %0d passed: digits %h underflow %b overflow %b", checked,
                     i_display.digits, i_display.underflow, i_display.overflow);
        end
        else
        begin
            o_errors++;
            $display("mismatch at %0t ns: test %0d expected %h/%b/%b, got %h/%b/%b", $time,
                     checked, expected.digits, expected.underflow, expected.overflow,
                     i_display.digits, i_display.underflow, i_display.overflow);
        end
        checked++;
    endtask

    always @(posedge i_clk)
    begin
        if (i_rst)
        begin
            exp_q.delete();
            pushed      = 0;
            checked     = 0;
            passed      = 0;
            valid_count = 0;
            o_errors    = 0;
        end
        else
        begin
            if (i_push)
            begin
                exp_q.push_back(i_expected);
                pushed++;
            end
            if (i_valid)
            begin
                valid_count++;
                if (exp_q.size() == 0)
                begin
                    o_errors++;
                    $display("o_valid pulsed at %0t ns while no test was waiting", $time);
                end
                else
                begin
                    compare_result(exp_q.pop_front());
                end
            end
            if (i_report)
            begin
                if (valid_count != pushed)
                begin
                    o_errors++;
                    $display("Got %0d result pulses for %0d tests", valid_count, pushed);
                end
                $display("Totals: %0d tests, %0d checked, %0d passed, %0d errors",
                         pushed, checked, passed, o_errors);
            end
        end
        o_pending = exp_q.size();
    end

endmodule

`default_nettype wire

// ==== dv/tb_period_meter.sv ====
// Testbench for the period meter.
// Applies a table of input periods, drives i_signal on falling clock edges
// and hands each expected display value to the checker.
`timescale 1ns/1ps
`default_nettype none

`include "period_meter_macros.svh"

module tb_period_meter;

    import period_meter_pkg::*;

    localparam int MAX_US      = `PM_TEST_MAX_US;
    localparam int OVF_CYCLES  = (MAX_US + 1) * `PM_CLKS_PER_US;
    localparam int FIXED_TESTS = 9;
    localparam int NUM_TESTS   = FIXED_TESTS + 8;
    localparam int SLACK       = 200;

    logic        clk;
    logic        rst;
    logic        start;
    logic        sig_in;
    logic        ready;
    logic        valid;
    display_t    disp;
    logic        exp_push;
    display_t    exp_value;
    logic        report;
    int          pending;
    int          chk_errors;
    int          tb_errors;
    int unsigned cycle_count;
    int unsigned cycle_limit;
    logic [31:0] rand_state;

    // Stimulus table with the expected display value of every test.
    int unsigned tbl_gap [NUM_TESTS];
    int unsigned tbl_delay [NUM_TESTS];
    bit          tbl_no_second [NUM_TESTS];
    bit          tbl_extra_start [NUM_TESTS];
    display_t    tbl_expected [NUM_TESTS];

    period_meter_top #(
        .MAX_US (MAX_US)
    ) i_period_meter_top (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_start   (start),
        .i_signal  (sig_in),
        .o_ready   (ready),
        .o_valid   (valid),
        .o_display (disp)
    );

    period_meter_checker i_checker (
        .i_clk      (clk),
        .i_rst      (rst),
        .i_push     (exp_push),
        .i_expected (exp_value),
        .i_valid    (valid),
        .i_display  (disp),
        .i_report   (report),
        .o_pending  (pending),
        .o_errors   (chk_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Decimal digits of a value, least significant digit in the low nibble.
    function automatic bcd_digits_t to_bcd(input int unsigned value);
        bcd_digits_t digits;
        int unsigned rest;
        digits = '0;
        rest   = value;
        for (int i = 0; i < `PM_BCD_DIGITS; i++)
        begin
            digits[4*i +: 4] = 4'(rest % 10);
            rest = rest / 10;
        end
        return digits;
    endfunction

    function automatic display_t expected_from_gap(input int unsigned gap);
        display_t result;
        result = '0;
        if (gap >= OVF_CYCLES)
        begin
            result.overflow = 1'b1;
        end
        else if (gap < `PM_CLKS_PER_US)
        begin
            result.underflow = 1'b1;
        end
        else
        begin
            result.digits = to_bcd(gap / `PM_CLKS_PER_US);
        end
        return result;
    endfunction

    task automatic set_entry(input int idx, input int unsigned gap, input int unsigned delay,
                             input bit no_second, input bit extra_start,
                             input bcd_digits_t digits, input bit uf, input bit of);
        tbl_gap[idx]                = gap;
        tbl_delay[idx]              = delay;
        tbl_no_second[idx]          = no_second;
        tbl_extra_start[idx]        = extra_start;
        tbl_expected[idx].digits    = digits;
        tbl_expected[idx].underflow = uf;
        tbl_expected[idx].overflow  = of;
    endtask

    task automatic build_table();
        display_t    exp;
        int unsigned gap;
        int unsigned total;
        set_entry(0, 100, 3, 0, 0, 24'h000001, 0, 0);
        set_entry(1, 500, 0, 0, 1, 24'h000005, 0, 0);
        set_entry(2, 3700, 7, 0, 0, 24'h000037, 0, 0);
        set_entry(3, 199, 2, 0, 0, 24'h000001, 0, 0);
        set_entry(4, 25099, 5, 0, 1, 24'h000250, 0, 0);
        set_entry(5, 40, 1, 0, 0, 24'h000000, 1, 0);
        set_entry(6, 100500, 4, 0, 0, 24'h000000, 0, 1);
        // No second edge, so the counter runs until it overflows.
        set_entry(7, OVF_CYCLES, 6, 1, 0, 24'h000000, 0, 1);
        // A short period right after the overflow finds the converter still busy,
        // so the counter has to wait in hold.
        set_entry(8, 8, 0, 0, 0, 24'h000000, 1, 0);
        rand_state = 32'd33468;
        for (int i = FIXED_TESTS; i < NUM_TESTS; i++)
        begin
            rand_state = next_random(rand_state);
            gap = 2 + rand_state % 98998;
            exp = expected_from_gap(gap);
            set_entry(i, gap, rand_state >> 28, 0, (i % 2 == 0) && (gap >= 200),
                      exp.digits, exp.underflow, exp.overflow);
        end
        total = 0;
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            total += tbl_gap[i] + SLACK;
        end
        cycle_limit = total;
    endtask

    task automatic run_test(input int idx);
        int unsigned high_cycles;
        int unsigned low_cycles;
        int unsigned first_part;
        high_cycles = (tbl_gap[idx] / 2 < 50) ? tbl_gap[idx] / 2 : 50;
        low_cycles  = tbl_gap[idx] - high_cycles;
        while (!ready)
        begin
            @(negedge clk);
        end
        start     = 1'b1;
        exp_push  = 1'b1;
        exp_value = tbl_expected[idx];
        @(negedge clk);
        start    = 1'b0;
        exp_push = 1'b0;
        repeat (tbl_delay[idx]) @(negedge clk);
        sig_in = 1'b1;
        repeat (high_cycles) @(negedge clk);
        sig_in = 1'b0;
        if (!tbl_no_second[idx])
        begin
            if (tbl_extra_start[idx])
            begin
                // A start pulse in the middle of a measurement must be ignored.
                first_part = low_cycles / 2;
                repeat (first_part) @(negedge clk);
                if (ready)
                begin
                    tb_errors++;
                    $display("mismatch at %0t ns: o_ready high in the middle of test %0d",
                             $time, idx);
                end
                start = 1'b1;
                @(negedge clk);
                start = 1'b0;
                repeat (low_cycles - first_part - 1) @(negedge clk);
            end
            else
            begin
                repeat (low_cycles) @(negedge clk);
            end
            sig_in = 1'b1;
            repeat (2) @(negedge clk);
            sig_in = 1'b0;
        end
        // Let a late rise pulse pass before the counter is armed again.
        repeat (4) @(negedge clk);
    endtask

    initial
    begin
        cycle_count = 0;
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        rst       = 1'b1;
        start     = 1'b0;
        sig_in    = 1'b0;
        exp_push  = 1'b0;
        exp_value = '0;
        report    = 1'b0;
        tb_errors = 0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        if (!ready || valid || disp.underflow || disp.overflow)
        begin
            tb_errors++;
            $display("mismatch at %0t ns: o_ready, o_valid or a display flag wrong after reset",
                     $time);
        end
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            run_test(i);
        end
        while (!ready || pending != 0)
        begin
            @(negedge clk);
        end
        // Leave room for a stray o_valid before the totals are taken.
        repeat (40) @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (tb_errors == 0 && chk_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== include/period_meter_macros.svh ====
// Shared constants for the period meter.
// Include this wherever a clock rate, a width or a limit is needed.
`ifndef PERIOD_METER_MACROS_SVH
`define PERIOD_METER_MACROS_SVH

// Clock cycles in one microsecond at the 100 MHz system clock.
`define PM_CLKS_PER_US 100

// Width of a measured period in microseconds.
`define PM_PERIOD_W 20

// Default overflow limit in microseconds.
`define PM_MAX_US 999999

// Number of BCD digits shown on the display.
`define PM_BCD_DIGITS 6

// Lower overflow limit for short simulation runs.
`define PM_TEST_MAX_US 999

`endif

// ==== rtl/bcd_converter.sv ====
// Sequential binary to BCD converter using the shift and add-3 method.
// A pulse on i_load starts a conversion of one bit per cycle; o_valid pulses
// 21 cycles later with the digits and the flags in o_display.
`timescale 1ns/1ps
`default_nettype none

`include "period_meter_macros.svh"

module bcd_converter
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_load,
    input  wire period_meter_pkg::meas_result_t i_result,
    output logic                            o_busy,
    output logic                            o_valid,
    output period_meter_pkg::display_t     o_display
);

    import period_meter_pkg::*;

    localparam int STEP_W = $clog2(`PM_PERIOD_W);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`PM_PERIOD_W - 1);
    localparam int BCD_W = 4 * `PM_BCD_DIGITS;

    logic        r_busy;
    logic        r_finish;
    logic        r_valid;
    logic [STEP_W-1:0] r_step;
    logic        r_disp_underflow;
    logic        r_disp_overflow;
    period_us_t  r_bin;
    bcd_digits_t r_bcd;
    bcd_digits_t w_bcd_adj;
    bcd_digits_t r_disp_digits;
    logic        r_underflow;
    logic        r_overflow;
    logic        w_shift;

    // Shifting runs while busy, up to the final output cycle.
    assign w_shift = r_busy && !r_finish;

    // Every digit of five or more gets three added before the next shift.
    always_comb
    begin
        w_bcd_adj = r_bcd;
        for (int i = 0; i < `PM_BCD_DIGITS; i++)
        begin
            if (r_bcd[4*i +: 4] >= 4'd5)
            begin
                w_bcd_adj[4*i +: 4] = r_bcd[4*i +: 4] + 4'd3;
            end
        end
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_busy           <= 1'b0;
            r_finish         <= 1'b0;
            r_valid          <= 1'b0;
            r_step           <= '0;
            r_disp_underflow <= 1'b0;
            r_disp_overflow  <= 1'b0;
        end
        else
        begin
            r_valid <= 1'b0;
            if (i_load)
            begin
                r_busy   <= 1'b1;
                r_finish <= 1'b0;
                r_step   <= '0;
            end
            else if (r_finish)
            begin
                r_busy           <= 1'b0;
                r_finish         <= 1'b0;
                r_valid          <= 1'b1;
                r_disp_underflow <= r_underflow;
                r_disp_overflow  <= r_overflow;
            end
            else if (w_shift)
            begin
                r_step <= r_step + 1'b1;
                if (r_step == STEP_LAST)
                begin
                    r_finish <= 1'b1;
                end
            end
        end
    end

    // Data path.
    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            r_bin       <= i_result.period;
            r_bcd       <= '0;
            r_underflow <= i_result.underflow;
            r_overflow  <= i_result.overflow;
        end
        else if (r_finish)
        begin
            r_disp_digits <= r_bcd;
        end
        else if (w_shift)
        begin
            r_bcd <= {w_bcd_adj[BCD_W-2:0], r_bin[`PM_PERIOD_W-1]};
            r_bin <= {r_bin[`PM_PERIOD_W-2:0], 1'b0};
        end
    end

    assign o_busy              = r_busy;
    assign o_valid             = r_valid;
    assign o_display.digits    = r_disp_digits;
    assign o_display.underflow = r_disp_underflow;
    assign o_display.overflow  = r_disp_overflow;

    // The counter holds its result while we are busy, so no load may overlap.
    a_no_load_when_busy : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_load |-> !o_busy
    );

endmodule

`default_nettype wire

// ==== rtl/period_counter_us.sv ====
// Measures the time between two rise pulses in whole microseconds.
// Arm with i_start while o_ready is high. The result with its underflow and
// overflow flags is valid while o_done pulses. The counter waits while the
// downstream converter is busy, so no result is lost.
`timescale 1ns/1ps
`default_nettype none

`include "period_meter_macros.svh"

module period_counter_us
#(
    parameter int MAX_US = `PM_MAX_US
)
(
    input  wire                             i_clk,
    input  wire                             i_rst,
    input  wire                             i_start,
    input  wire                             i_rise,
    input  wire                             i_sink_busy,
    output logic                            o_ready,
    output logic                            o_done,
    output period_meter_pkg::meas_result_t o_result
);

    import period_meter_pkg::*;

    localparam int CLK_W = $clog2(`PM_CLKS_PER_US);
    localparam logic [CLK_W-1:0] CLK_LAST = CLK_W'(`PM_CLKS_PER_US - 1);
    localparam period_us_t LIMIT_US = period_us_t'(MAX_US + 1);

    meas_state_t  r_state;
    meas_state_t  w_state_next;
    logic [CLK_W-1:0] r_clk_cnt;
    logic [CLK_W-1:0] w_clk_cnt_next;
    period_us_t   r_us_cnt;
    period_us_t   w_us_cnt_next;
    meas_result_t r_result;
    meas_result_t w_result_next;

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_state   <= ST_IDLE;
            r_clk_cnt <= '0;
            r_us_cnt  <= '0;
            r_result  <= '0;
        end
        else
        begin
            r_state   <= w_state_next;
            r_clk_cnt <= w_clk_cnt_next;
            r_us_cnt  <= w_us_cnt_next;
            r_result  <= w_result_next;
        end
    end

    always_comb
    begin
        w_state_next   = r_state;
        w_clk_cnt_next = r_clk_cnt;
        w_us_cnt_next  = r_us_cnt;
        w_result_next  = r_result;

        case (r_state)
            ST_IDLE:
            begin
                if (i_start)
                begin
                    w_state_next = ST_WAIT_FIRST;
                end
            end
            ST_WAIT_FIRST:
            begin
                // The cycle after the first edge already counts as one clock.
                if (i_rise)
                begin
                    w_state_next   = ST_MEASURE;
                    w_clk_cnt_next = CLK_W'(1);
                    w_us_cnt_next  = '0;
                end
            end
            ST_MEASURE:
            begin
                // Overflow wins over an edge arriving in the same cycle.
                if (r_us_cnt == LIMIT_US)
                begin
                    w_result_next.period    = r_us_cnt;
                    w_result_next.underflow = 1'b0;
                    w_result_next.overflow  = 1'b1;
                    w_state_next = i_sink_busy ? ST_HOLD : ST_REPORT;
                end
                else if (i_rise)
                begin
                    w_result_next.period    = r_us_cnt;
                    w_result_next.underflow = (r_us_cnt == '0);
                    w_result_next.overflow  = 1'b0;
                    w_state_next = i_sink_busy ? ST_HOLD : ST_REPORT;
                end
                else if (r_clk_cnt == CLK_LAST)
                begin
                    w_clk_cnt_next = '0;
                    w_us_cnt_next  = r_us_cnt + 1'b1;
                end
                else
                begin
                    w_clk_cnt_next = r_clk_cnt + 1'b1;
                end
            end
            ST_HOLD:
            begin
                if (!i_sink_busy)
                begin
                    w_state_next = ST_REPORT;
                end
            end
            ST_REPORT:
            begin
                w_state_next = ST_IDLE;
            end
            default:
            begin
                w_state_next = ST_IDLE;
            end
        endcase
    end

    assign o_ready  = (r_state == ST_IDLE);
    assign o_done   = (r_state == ST_REPORT);
    assign o_result = r_result;

    // The hold state must keep a result back until the converter is free.
    a_done_not_busy : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_done |-> !i_sink_busy
    );

    // A reported result carries at most one of the two flags.
    a_flags_exclusive : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_done |-> !(o_result.underflow && o_result.overflow)
    );

endmodule

`default_nettype wire

// ==== rtl/period_meter_pkg.sv ====
// Types shared by the period meter blocks.
// Modules import this package inside their bodies and use scoped names in port lists.
`default_nettype none

`include "period_meter_macros.svh"

package period_meter_pkg;

    // A period in whole microseconds.
    typedef logic [`PM_PERIOD_W-1:0] period_us_t;

    // Packed BCD digits, most significant digit in the top nibble.
    typedef logic [4*`PM_BCD_DIGITS-1:0] bcd_digits_t;

    // Result of one measurement as produced by the counter.
    typedef struct packed {
        period_us_t period;
        logic       underflow;
        logic       overflow;
    } meas_result_t;

    // Result as shown on the display.
    typedef struct packed {
        bcd_digits_t digits;
        logic        underflow;
        logic        overflow;
    } display_t;

    // States of the period counter FSM.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_FIRST,
        ST_MEASURE,
        ST_HOLD,
        ST_REPORT
    } meas_state_t;

endpackage

`default_nettype wire

// ==== rtl/period_meter_top.sv ====
// Single channel period meter.
// Pulse i_start while o_ready is high; after two rising edges on i_signal
// the period in microseconds appears as BCD digits when o_valid pulses.
`timescale 1ns/1ps
`default_nettype none

`include "period_meter_macros.svh"

module period_meter_top
#(
    parameter int MAX_US = `PM_MAX_US
)
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_start,
    input  wire                         i_signal,
    output logic                        o_ready,
    output logic                        o_valid,
    output period_meter_pkg::display_t o_display
);

    import period_meter_pkg::*;

    logic         w_rise;
    logic         w_done;
    logic         w_busy;
    meas_result_t w_result;

    signal_sync i_signal_sync (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_signal (i_signal),
        .o_rise   (w_rise)
    );

    period_counter_us #(
        .MAX_US (MAX_US)
    ) i_period_counter_us (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_rise      (w_rise),
        .i_sink_busy (w_busy),
        .o_ready     (o_ready),
        .o_done      (w_done),
        .o_result    (w_result)
    );

    bcd_converter i_bcd_converter (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_load    (w_done),
        .i_result  (w_result),
        .o_busy    (w_busy),
        .o_valid   (o_valid),
        .o_display (o_display)
    );

endmodule

`default_nettype wire

// ==== rtl/signal_sync.sv ====
// Brings an asynchronous input into the clock domain and detects rising edges.
// o_rise pulses for one cycle, two cycles after the first clock that samples the input high.
`timescale 1ns/1ps
`default_nettype none

module signal_sync
(
    input  wire  i_clk,
    input  wire  i_rst,
    input  wire  i_signal,
    output logic o_rise
);

    logic r_meta;
    logic r_sync;
    logic r_prev;
    logic r_rise;

    // Two flops resolve metastability, the third keeps the previous synchronized level.
    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_meta <= 1'b0;
            r_sync <= 1'b0;
            r_prev <= 1'b0;
            r_rise <= 1'b0;
        end
        else
        begin
            r_meta <= i_signal;
            r_sync <= r_meta;
            r_prev <= r_sync;
            r_rise <= r_sync & ~r_prev;
        end
    end

    assign o_rise = r_rise;

    // A rise needs the previous level low, so two pulses in a row cannot happen.
    a_rise_single_cycle : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_rise |=> !o_rise
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/period_meter_pkg.sv
rtl/signal_sync.sv
rtl/period_counter_us.sv
rtl/bcd_converter.sv
rtl/period_meter_top.sv
dv/period_meter_checker.sv
dv/tb_period_meter.sv
